//--- lsu_pkg.sv
/*
 * Shared definitions for the load/store unit: data widths, operation,
 * size and exception cause encodings, and the request and response
 * records that travel between the pipeline stages.
 * Stages refer to everything here through scoped names.
 */

package lsu_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned STRB_W     = XLEN / 8;
    localparam int unsigned TRANS_ID_W = 3;

    // bit 3 store, bit 2 unsigned load, bits 1:0 size
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10
    } lsu_size_e;

    // RISC-V mcause values for data accesses
    typedef enum logic [3:0] {
        NO_CAUSE           = 4'd0,
        LD_ADDR_MISALIGNED = 4'd4,
        LD_ACCESS_FAULT    = 4'd5,
        ST_ADDR_MISALIGNED = 4'd6,
        ST_ACCESS_FAULT    = 4'd7
    } exc_cause_e;

    typedef struct packed {
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       wdata;
        logic [STRB_W-1:0]     strb;
        lsu_op_e               op;
        logic [TRANS_ID_W-1:0] trans_id;
        logic                  misaligned;
    } lsu_req_t;

    typedef struct packed {
        logic [XLEN-1:0]       rdata;
        logic [1:0]            byte_off;
        lsu_op_e               op;
        logic [TRANS_ID_W-1:0] trans_id;
        logic                  misaligned;
        logic                  bus_error;
    } lsu_rsp_t;

    function automatic lsu_size_e op_size(lsu_op_e op);
        return lsu_size_e'(op[1:0]);
    endfunction

    function automatic logic op_is_store(lsu_op_e op);
        return op[3];
    endfunction

    function automatic logic op_is_unsigned(lsu_op_e op);
        return op[2];
    endfunction

endpackage

//--- lsu_req_if.sv
/*
 * Request channel from the address stage to the memory stage.
 * A request moves on a clock edge where valid and ready are both high;
 * the address stage keeps req stable while it waits for ready.
 */

`timescale 1ns/1ps

interface lsu_req_if;

    logic              valid;
    logic              ready;
    lsu_pkg::lsu_req_t req;

    // address stage side
    modport agu (
        output valid,
        output req,
        input  ready
    );

    // memory stage side
    modport mem (
        input  valid,
        input  req,
        output ready
    );

endinterface

//--- lsu_rsp_if.sv
/*
 * Response channel from the memory stage to the writeback stage.
 * valid pulses for one cycle per finished access; the writeback
 * stage takes every pulse, so there is no ready.
 */

`timescale 1ns/1ps

interface lsu_rsp_if;

    logic              valid;
    lsu_pkg::lsu_rsp_t rsp;

    // memory stage side
    modport mem (
        output valid,
        output rsp
    );

    // writeback stage side
    modport wb (
        input valid,
        input rsp
    );

endinterface

//--- lsu_agu_stage.sv
/*
 * Address stage of the load/store unit. Computes the effective address,
 * byte strobes and lane-shifted store data, flags misaligned accesses
 * and holds the result in a one-entry request register until the
 * memory stage takes it.
 */

`timescale 1ns/1ps

module lsu_agu_stage (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             valid_i,
    output logic                             ready_o,
    input  logic [lsu_pkg::XLEN-1:0]         base_i,
    input  logic [lsu_pkg::XLEN-1:0]         imm_i,
    input  logic [lsu_pkg::XLEN-1:0]         wdata_i,
    input  lsu_pkg::lsu_op_e                 op_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0]   trans_id_i,
    lsu_req_if.agu                           req
);

    logic [lsu_pkg::XLEN-1:0]   addr;
    logic [lsu_pkg::STRB_W-1:0] strb;
    logic                       misaligned;
    lsu_pkg::lsu_size_e         size;
    lsu_pkg::lsu_req_t          req_d;
    lsu_pkg::lsu_req_t          req_q;
    logic                       valid_q;
    logic                       accept;

    // ------------------------------------------------------------------------
    // address generation
    // ------------------------------------------------------------------------
    // immediate arrives sign-extended to full width
    assign addr = $unsigned($signed(base_i) + $signed(imm_i));
    assign size = lsu_pkg::op_size(op_i);

    always_comb begin
        strb       = '1;
        misaligned = 1'b0;
        case (size)
            lsu_pkg::SIZE_B: begin
                strb = lsu_pkg::STRB_W'(1) << addr[1:0];
            end
            lsu_pkg::SIZE_H: begin
                strb       = lsu_pkg::STRB_W'(3) << addr[1:0];
                misaligned = addr[0];
            end
            default: begin
                strb       = '1;
                misaligned = |addr[1:0];
            end
        endcase
    end

    always_comb begin
        req_d            = '0;
        req_d.addr       = addr;
        // store data moves to the lane picked by the low address bits
        req_d.wdata      = wdata_i << {addr[1:0], 3'b000};
        req_d.strb       = strb;
        req_d.op         = op_i;
        req_d.trans_id   = trans_id_i;
        req_d.misaligned = misaligned;
    end

    // ------------------------------------------------------------------------
    // request register
    // ------------------------------------------------------------------------
    // free when empty or drained this cycle
    assign ready_o = ~valid_q | req.ready;
    assign accept  = valid_i & ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (req.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= req_d;
        end
    end

    assign req.valid = valid_q;
    assign req.req   = req_q;

endmodule

//--- lsu_apb_stage.sv
/*
 * Memory stage of the load/store unit. Takes one request at a time and
 * runs it as an APB3 transfer: a setup cycle, then access cycles until
 * pready_i. Misaligned requests never reach the bus and answer one cycle
 * after they are taken. Each finished request gives a single-cycle
 * response with the raw bus word and the error status.
 */

`timescale 1ns/1ps

module lsu_apb_stage (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    lsu_req_if.mem                       req,
    lsu_rsp_if.mem                       rsp,
    output logic [lsu_pkg::XLEN-1:0]     paddr_o,
    output logic [lsu_pkg::XLEN-1:0]     pwdata_o,
    output logic                         psel_o,
    output logic                         penable_o,
    output logic                         pwrite_o,
    output logic [lsu_pkg::STRB_W-1:0]   pstrb_o,
    input  logic [lsu_pkg::XLEN-1:0]     prdata_i,
    input  logic                         pready_i,
    input  logic                         pslverr_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } apb_state_e;

    apb_state_e        state_q;
    apb_state_e        state_d;
    lsu_pkg::lsu_req_t req_q;
    logic              take;
    logic              skip_q;
    logic              is_store;
    logic              bus_done;
    lsu_pkg::lsu_rsp_t rsp_d;

    // only one request in the stage at a time
    assign req.ready = (state_q == ST_IDLE);
    assign take      = req.valid & req.ready;

    // ------------------------------------------------------------------------
    // transfer FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (take && !req.req.misaligned) begin
                    state_d = ST_SETUP;
                end
            end
            ST_SETUP: begin
                state_d = ST_ACCESS;
            end
            ST_ACCESS: begin
                if (pready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            skip_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // faulted request answers next cycle without a bus transfer
            skip_q  <= take & req.req.misaligned;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            req_q <= req.req;
        end
    end

    // ------------------------------------------------------------------------
    // APB master outputs
    // ------------------------------------------------------------------------
    assign is_store  = lsu_pkg::op_is_store(req_q.op);
    assign paddr_o   = {req_q.addr[lsu_pkg::XLEN-1:2], 2'b00};
    assign pwdata_o  = req_q.wdata;
    assign psel_o    = (state_q != ST_IDLE);
    assign penable_o = (state_q == ST_ACCESS);
    assign pwrite_o  = is_store;
    // loads read the whole word
    assign pstrb_o   = is_store ? req_q.strb : '0;

    // ------------------------------------------------------------------------
    // response
    // ------------------------------------------------------------------------
    assign bus_done = (state_q == ST_ACCESS) & pready_i;

    always_comb begin
        rsp_d            = '0;
        rsp_d.rdata      = skip_q ? '0 : prdata_i;
        rsp_d.byte_off   = req_q.addr[1:0];
        rsp_d.op         = req_q.op;
        rsp_d.trans_id   = req_q.trans_id;
        rsp_d.misaligned = req_q.misaligned;
        rsp_d.bus_error  = bus_done & pslverr_i;
    end

    assign rsp.valid = bus_done | skip_q;
    assign rsp.rsp   = rsp_d;

endmodule

//--- lsu_writeback_stage.sv
/*
 * Writeback stage of the load/store unit. Picks the loaded byte or
 * halfword out of the bus word, extends it, turns misalignment and bus
 * errors into a RISC-V exception cause and registers the result.
 * valid_o follows each response pulse by one cycle.
 */

`timescale 1ns/1ps

module lsu_writeback_stage (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    lsu_rsp_if.wb                          rsp,
    output logic                           valid_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0] trans_id_o,
    output logic [lsu_pkg::XLEN-1:0]       rdata_o,
    output logic                           exc_o,
    output lsu_pkg::exc_cause_e            cause_o
);

    logic [lsu_pkg::XLEN-1:0] shifted;
    logic [lsu_pkg::XLEN-1:0] load_data;
    logic [lsu_pkg::XLEN-1:0] rdata_d;
    logic                     is_store;
    logic                     sext;
    logic                     exc_d;
    lsu_pkg::exc_cause_e      cause_d;

    assign is_store = lsu_pkg::op_is_store(rsp.rsp.op);
    assign sext     = ~lsu_pkg::op_is_unsigned(rsp.rsp.op);

    // bring the addressed lane down to bit 0
    assign shifted = rsp.rsp.rdata >> {rsp.rsp.byte_off, 3'b000};

    always_comb begin
        case (lsu_pkg::op_size(rsp.rsp.op))
            lsu_pkg::SIZE_B: begin
                load_data = {{(lsu_pkg::XLEN-8){sext & shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::SIZE_H: begin
                load_data = {{(lsu_pkg::XLEN-16){sext & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                load_data = shifted;
            end
        endcase
    end

    // misalignment wins over a bus error
    always_comb begin
        exc_d   = rsp.rsp.misaligned | rsp.rsp.bus_error;
        cause_d = lsu_pkg::NO_CAUSE;
        if (rsp.rsp.misaligned) begin
            cause_d = is_store ? lsu_pkg::ST_ADDR_MISALIGNED : lsu_pkg::LD_ADDR_MISALIGNED;
        end else if (rsp.rsp.bus_error) begin
            cause_d = is_store ? lsu_pkg::ST_ACCESS_FAULT : lsu_pkg::LD_ACCESS_FAULT;
        end
    end

    assign rdata_d = (exc_d || is_store) ? '0 : load_data;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
            exc_o   <= 1'b0;
            cause_o <= lsu_pkg::NO_CAUSE;
        end else begin
            valid_o <= rsp.valid;
            exc_o   <= rsp.valid & exc_d;
            if (rsp.valid) begin
                cause_o <= cause_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp.valid) begin
            trans_id_o <= rsp.rsp.trans_id;
            rdata_o    <= rdata_d;
        end
    end

endmodule

//--- lsu_top.sv
/*
 * Top level of the load/store unit. Core requests enter over a
 * valid/ready handshake, memory is reached through an APB3 master port
 * and results leave in request order on a single writeback port.
 */

`timescale 1ns/1ps

module lsu_top (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    // core request side
    input  logic                           valid_i,
    output logic                           ready_o,
    input  logic [lsu_pkg::XLEN-1:0]       base_i,
    input  logic [lsu_pkg::XLEN-1:0]       imm_i,
    input  logic [lsu_pkg::XLEN-1:0]       wdata_i,
    input  lsu_pkg::lsu_op_e               op_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0] trans_id_i,

    // writeback side
    output logic                           valid_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0] trans_id_o,
    output logic [lsu_pkg::XLEN-1:0]       rdata_o,
    output logic                           exc_o,
    output lsu_pkg::exc_cause_e            cause_o,

    // APB3 master
    output logic [lsu_pkg::XLEN-1:0]       paddr_o,
    output logic                           psel_o,
    output logic                           penable_o,
    output logic                           pwrite_o,
    output logic [lsu_pkg::XLEN-1:0]       pwdata_o,
    output logic [lsu_pkg::STRB_W-1:0]     pstrb_o,
    input  logic [lsu_pkg::XLEN-1:0]       prdata_i,
    input  logic                           pready_i,
    input  logic                           pslverr_i
);

    lsu_req_if req_if ();
    lsu_rsp_if rsp_if ();

    lsu_agu_stage agu_stage_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .valid_i    (valid_i),
        .ready_o    (ready_o),
        .base_i     (base_i),
        .imm_i      (imm_i),
        .wdata_i    (wdata_i),
        .op_i       (op_i),
        .trans_id_i (trans_id_i),
        .req        (req_if.agu)
    );

    lsu_apb_stage apb_stage_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req       (req_if.mem),
        .rsp       (rsp_if.mem),
        .paddr_o   (paddr_o),
        .pwdata_o  (pwdata_o),
        .psel_o    (psel_o),
        .penable_o (penable_o),
        .pwrite_o  (pwrite_o),
        .pstrb_o   (pstrb_o),
        .prdata_i  (prdata_i),
        .pready_i  (pready_i),
        .pslverr_i (pslverr_i)
    );

    lsu_writeback_stage wb_stage_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rsp        (rsp_if.wb),
        .valid_o    (valid_o),
        .trans_id_o (trans_id_o),
        .rdata_o    (rdata_o),
        .exc_o      (exc_o),
        .cause_o    (cause_o)
    );

endmodule

//--- tb_apb_memory.sv
/*
 * APB3 slave memory model for the load/store unit testbench.
 * Holds 1K words, adds 0 to 3 wait states per transfer from an LFSR
 * and answers with pslverr for any address whose bits 15:12 are all ones.
 * Writes honour pstrb, and a faulted write leaves the array untouched.
 */

`timescale 1ns/1ps

module tb_apb_memory (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic [31:0] paddr_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [31:0] pwdata_i,
    input  logic [3:0]  pstrb_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o
);

    localparam logic [31:0] LFSR_SEED = 32'hedf8802a;

    logic [31:0] mem [1024];
    logic [31:0] lfsr_q;
    logic [31:0] lfsr_1;
    logic [31:0] lfsr_2;
    logic [1:0]  wait_q;
    logic [9:0]  index;
    logic        fault;
    logic [31:0] byte_mask;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    assign index     = paddr_i[11:2];
    assign fault     = (paddr_i[15:12] == 4'hf);
    assign lfsr_1    = lfsr_next(lfsr_q);
    assign lfsr_2    = lfsr_next(lfsr_1);
    assign prdata_o  = mem[index];
    assign pready_o  = (wait_q == 2'd0);
    assign pslverr_o = psel_i & penable_i & fault;

    // each strobe covers its own byte lane
    assign byte_mask = {{8{pstrb_i[3]}}, {8{pstrb_i[2]}}, {8{pstrb_i[1]}}, {8{pstrb_i[0]}}};

    // fill pattern mixes every address bit
    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h6b1c0000 ^ (i * 32'h00030507);
        end
    end

    // one LFSR step per wait-state bit, drawn in the setup cycle
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lfsr_q <= LFSR_SEED;
            wait_q <= 2'd0;
        end else if (psel_i && !penable_i) begin
            lfsr_q <= lfsr_2;
            wait_q <= {lfsr_1[0], lfsr_2[0]};
        end else if (psel_i && penable_i && wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    always @(posedge clk_i) begin
        if (psel_i && penable_i && pready_o && pwrite_i && !fault) begin
            mem[index] <= (mem[index] & ~byte_mask) | (pwdata_i & byte_mask);
        end
    end

endmodule

//--- tb_lsu.sv
/*
 * Testbench for the load/store unit. Applies a table of loads and stores
 * on the falling clock edge, checks every result in issue order against
 * the expected data, exception flag and cause, and prints a summary.
 * The APB side is served by the wait-state memory model.
 */

`timescale 1ns/1ps

module tb_lsu;

    typedef struct {
        lsu_pkg::lsu_op_e             op;
        logic [lsu_pkg::XLEN-1:0]       base;
        logic [lsu_pkg::XLEN-1:0]       imm;
        logic [lsu_pkg::XLEN-1:0]       wdata;
        logic [lsu_pkg::TRANS_ID_W-1:0] id;
        logic [lsu_pkg::XLEN-1:0]       rdata;
        logic                           exc;
        logic [3:0]                     cause;
    } vector_t;

    logic                           clk_i;
    logic                           rst_ni;
    logic                           valid_i;
    logic                           ready_o;
    logic [lsu_pkg::XLEN-1:0]       base_i;
    logic [lsu_pkg::XLEN-1:0]       imm_i;
    logic [lsu_pkg::XLEN-1:0]       wdata_i;
    lsu_pkg::lsu_op_e               op_i;
    logic [lsu_pkg::TRANS_ID_W-1:0] trans_id_i;
    logic                           valid_o;
    logic [lsu_pkg::TRANS_ID_W-1:0] trans_id_o;
    logic [lsu_pkg::XLEN-1:0]       rdata_o;
    logic                           exc_o;
    lsu_pkg::exc_cause_e            cause_o;
    logic [lsu_pkg::XLEN-1:0]       paddr_o;
    logic                           psel_o;
    logic                           penable_o;
    logic                           pwrite_o;
    logic [lsu_pkg::XLEN-1:0]       pwdata_o;
    logic [lsu_pkg::STRB_W-1:0]     pstrb_o;
    logic [lsu_pkg::XLEN-1:0]       prdata_i;
    logic                           pready_i;
    logic                           pslverr_i;

    vector_t vectors[$];
    int      pending_q[$];
    int      error_count  = 0;
    int      check_count  = 0;
    int      result_count = 0;
    int      cycle_count  = 0;
    int      cycle_limit  = 0;
    int      head;

    lsu_top lsu_top_i (
        .clk_i      (clk_i),      .rst_ni    (rst_ni),
        .valid_i    (valid_i),    .ready_o   (ready_o),
        .base_i     (base_i),     .imm_i     (imm_i),
        .wdata_i    (wdata_i),    .op_i      (op_i),
        .trans_id_i (trans_id_i), .valid_o   (valid_o),
        .trans_id_o (trans_id_o), .rdata_o   (rdata_o),
        .exc_o      (exc_o),      .cause_o   (cause_o),
        .paddr_o    (paddr_o),    .psel_o    (psel_o),
        .penable_o  (penable_o),  .pwrite_o  (pwrite_o),
        .pwdata_o   (pwdata_o),   .pstrb_o   (pstrb_o),
        .prdata_i   (prdata_i),   .pready_i  (pready_i),
        .pslverr_i  (pslverr_i)
    );

    tb_apb_memory memory_i (
        .clk_i     (clk_i),    .rst_ni    (rst_ni),
        .paddr_i   (paddr_o),  .psel_i    (psel_o),
        .penable_i (penable_o), .pwrite_i (pwrite_o),
        .pwdata_i  (pwdata_o), .pstrb_i   (pstrb_o),
        .prdata_o  (prdata_i), .pready_o  (pready_i),
        .pslverr_o (pslverr_i)
    );

    always #4 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] t=%0t %s: got 0x%h, expected 0x%h", $time, name, actual, expected);
        end
    endtask

    task automatic add_entry(input lsu_pkg::lsu_op_e op, input logic [31:0] base,
                             input logic [31:0] imm, input logic [31:0] wdata,
                             input logic [2:0] id, input logic [31:0] rdata,
                             input logic exc, input logic [3:0] cause);
        vector_t v;
        v = '{op, base, imm, wdata, id, rdata, exc, cause};
        vectors.push_back(v);
    endtask

    task automatic report_counts();
        $display("checks: %0d, results: %0d, errors: %0d", check_count, result_count,
                 error_count);
    endtask

    // ------------------------------------------------------------------------
    // op, base, imm, wdata, trans_id, expected rdata, exc, cause
    // ------------------------------------------------------------------------
    task automatic build_vectors();
        add_entry(lsu_pkg::SW,  32'h100,  32'h0,        32'h8badf00d, 3'd0, 32'h0,        1'b0, 4'd0);
        add_entry(lsu_pkg::LW,  32'h100,  32'h0,        32'h0,        3'd1, 32'h8badf00d, 1'b0, 4'd0);
        add_entry(lsu_pkg::LB,  32'h100,  32'h3,        32'h0,        3'd2, 32'hffffff8b, 1'b0, 4'd0);
        add_entry(lsu_pkg::LBU, 32'h104,  32'hffffffff, 32'h0,        3'd3, 32'h0000008b, 1'b0, 4'd0);
        add_entry(lsu_pkg::LH,  32'h100,  32'h2,        32'h0,        3'd4, 32'hffff8bad, 1'b0, 4'd0);
        add_entry(lsu_pkg::LHU, 32'h100,  32'h2,        32'h0,        3'd5, 32'h00008bad, 1'b0, 4'd0);
        // partial stores keep the other bytes
        add_entry(lsu_pkg::SB,  32'h100,  32'h1,        32'h00000042, 3'd6, 32'h0,        1'b0, 4'd0);
        add_entry(lsu_pkg::SH,  32'h100,  32'h2,        32'h12347fee, 3'd7, 32'h0,        1'b0, 4'd0);
        add_entry(lsu_pkg::LW,  32'h100,  32'h0,        32'h0,        3'd0, 32'h7fee420d, 1'b0, 4'd0);
        add_entry(lsu_pkg::LH,  32'h100,  32'h2,        32'h0,        3'd1, 32'h00007fee, 1'b0, 4'd0);
        add_entry(lsu_pkg::LB,  32'h100,  32'h1,        32'h0,        3'd2, 32'h00000042, 1'b0, 4'd0);
        add_entry(lsu_pkg::LBU, 32'h100,  32'h0,        32'h0,        3'd3, 32'h0000000d, 1'b0, 4'd0);
        // misaligned accesses must not touch memory
        add_entry(lsu_pkg::SW,  32'h200,  32'h0,        32'h01234567, 3'd4, 32'h0,        1'b0, 4'd0);
        add_entry(lsu_pkg::SH,  32'h200,  32'h1,        32'h0000ffff, 3'd5, 32'h0,        1'b1, 4'd6);
        add_entry(lsu_pkg::SW,  32'h200,  32'h2,        32'hffffffff, 3'd6, 32'h0,        1'b1, 4'd6);
        add_entry(lsu_pkg::LW,  32'h200,  32'h0,        32'h0,        3'd7, 32'h01234567, 1'b0, 4'd0);
        add_entry(lsu_pkg::LH,  32'h200,  32'h3,        32'h0,        3'd0, 32'h0,        1'b1, 4'd4);
        add_entry(lsu_pkg::LW,  32'h200,  32'h1,        32'h0,        3'd1, 32'h0,        1'b1, 4'd4);
        // error region aliases word 0x10 in the model
        add_entry(lsu_pkg::SW,  32'h10,   32'h0,        32'h0badcafe, 3'd2, 32'h0,        1'b0, 4'd0);
        add_entry(lsu_pkg::SW,  32'hf000, 32'h10,       32'hdeadbeef, 3'd3, 32'h0,        1'b1, 4'd7);
        add_entry(lsu_pkg::LW,  32'hf000, 32'h10,       32'h0,        3'd4, 32'h0,        1'b1, 4'd5);
        add_entry(lsu_pkg::LB,  32'hfffc, 32'h3,        32'h0,        3'd5, 32'h0,        1'b1, 4'd5);
        add_entry(lsu_pkg::LH,  32'hf000, 32'h1,        32'h0,        3'd6, 32'h0,        1'b1, 4'd4);
        add_entry(lsu_pkg::LW,  32'h10,   32'h0,        32'h0,        3'd7, 32'h0badcafe, 1'b0, 4'd0);
        add_entry(lsu_pkg::SW,  32'h300,  32'h0,        32'h80706050, 3'd0, 32'h0,        1'b0, 4'd0);
        add_entry(lsu_pkg::SH,  32'h304,  32'h0,        32'h0000c3c3, 3'd1, 32'h0,        1'b0, 4'd0);
        add_entry(lsu_pkg::LH,  32'h304,  32'h0,        32'h0,        3'd2, 32'hffffc3c3, 1'b0, 4'd0);
        add_entry(lsu_pkg::LBU, 32'h300,  32'h3,        32'h0,        3'd3, 32'h00000080, 1'b0, 4'd0);
        add_entry(lsu_pkg::SB,  32'h300,  32'h3,        32'h000000ff, 3'd4, 32'h0,        1'b0, 4'd0);
        add_entry(lsu_pkg::LB,  32'h300,  32'h3,        32'h0,        3'd5, 32'hffffffff, 1'b0, 4'd0);
        add_entry(lsu_pkg::SB,  32'hf800, 32'h0,        32'h00000011, 3'd6, 32'h0,        1'b1, 4'd7);
        add_entry(lsu_pkg::LW,  32'h304,  32'hfffffffc, 32'h0,        3'd7, 32'hff706050, 1'b0, 4'd0);
    endtask

    // results are sampled away from the rising edge
    always @(negedge clk_i) begin
        if (rst_ni && valid_o) begin
            if (pending_q.size() == 0) begin
                error_count++;
                $display("result with trans_id %0d arrived with no request outstanding",
                         trans_id_o);
            end else begin
                head = pending_q.pop_front();
                result_count++;
                check_value("trans_id_o", 32'(trans_id_o), 32'(vectors[head].id));
                check_value("rdata_o", rdata_o, vectors[head].rdata);
                check_value("exc_o", 32'(exc_o), 32'(vectors[head].exc));
                check_value("cause_o", 32'(cause_o), 32'(vectors[head].cause));
            end
        end
    end

    initial begin
        @(posedge rst_ni);
        cycle_limit = 20 * vectors.size();
        while (cycle_count < cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d results outstanding", cycle_count,
                 pending_q.size());
        report_counts();
        $display("Some tests failed");
        $finish;
    end

    initial begin
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        valid_i    = 1'b0;
        base_i     = '0;
        imm_i      = '0;
        wdata_i    = '0;
        op_i       = lsu_pkg::LW;
        trans_id_i = '0;
        build_vectors();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // idle state straight after reset
        check_value("ready_o", 32'(ready_o), 32'd1);
        check_value("valid_o", 32'(valid_o), 32'd0);
        check_value("psel_o", 32'(psel_o), 32'd0);
        check_value("penable_o", 32'(penable_o), 32'd0);
        check_value("exc_o", 32'(exc_o), 32'd0);

        for (int i = 0; i < vectors.size(); i++) begin
            @(negedge clk_i);
            valid_i    = 1'b1;
            op_i       = vectors[i].op;
            base_i     = vectors[i].base;
            imm_i      = vectors[i].imm;
            wdata_i    = vectors[i].wdata;
            trans_id_i = vectors[i].id;
            // taken on the next rising edge once ready_o is high
            while (!ready_o) @(negedge clk_i);
            pending_q.push_back(i);
        end
        @(negedge clk_i);
        valid_i = 1'b0;

        while (pending_q.size() != 0) @(negedge clk_i);
        // a few idle cycles to catch duplicated results
        repeat (4) @(negedge clk_i);
        check_value("result count", 32'(result_count), 32'(vectors.size()));

        report_counts();
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- lsu.f
lsu_pkg.sv
lsu_req_if.sv
lsu_rsp_if.sv
lsu_agu_stage.sv
lsu_apb_stage.sv
lsu_writeback_stage.sv
lsu_top.sv
tb_apb_memory.sv
tb_lsu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the load/store unit testbench with Verilator and run it.
# Exits non-zero when the log reports a failure.

set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module tb_lsu \
    -Mdir obj_dir \
    -f lsu.f

./obj_dir/Vtb_lsu | tee "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

exit 0
